// ==== design/sbuf_defines.svh ====
`ifndef SBUF_DEFINES_SVH
`define SBUF_DEFINES_SVH

// Sample word width in bits
`define SBUF_WIDTH 8

// Address bits of the sample buffer, 2^SBUF_WBITS words deep
`define SBUF_WBITS 4

// First address of a sequential stream, and the per-transfer increment
`define SBUF_START 0
`define SBUF_STEP  1

`endif

// ==== design/wb_pkg.sv ====
`default_nettype none

`include "sbuf_defines.svh"

// ----------------------------------------------------------
// Bus-side types for the pipelined Wishbone-like ports
// ----------------------------------------------------------
package wb_pkg;

   // Word address into the sample buffer
   typedef logic [`SBUF_WBITS-1:0] adr_t;

   // Transfer direction, as carried on the we lines
   typedef enum logic {
      WB_READ  = 1'b0,
      WB_WRITE = 1'b1
   } dir_e;

endpackage

`default_nettype wire

// ==== design/smp_pkg.sv ====
`default_nettype none

`include "sbuf_defines.svh"

// ----------------------------------------------------------
// Sample-side types
// ----------------------------------------------------------
package smp_pkg;

   // One receiver sample, as stored in the buffer
   typedef logic [`SBUF_WIDTH-1:0] sample_t;

   // Word count, one bit wider than the address
   // so that a full buffer (2^WBITS words) fits
   typedef logic [`SBUF_WBITS:0] count_t;

endpackage

`default_nettype wire

// ==== design/wb_stream_adr.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module wb_stream_adr #(
   parameter int WBITS = `SBUF_WBITS,
   parameter int START = `SBUF_START,
   parameter int STEP  = `SBUF_STEP
) (
   input  logic             clk_i,
   input  logic             rst_i,

   // Streaming slave side without an address from the master
   input  logic             s_cyc_i,
   input  logic             s_stb_i,
   input  wb_pkg::dir_e     s_we_i,
   input  smp_pkg::sample_t s_dat_i,
   output logic             s_ack_o,
   output logic             s_wat_o,
   output smp_pkg::sample_t s_dat_o,

   // Master side towards the block RAM
   output logic             m_cyc_o,
   output logic             m_stb_o,
   output wb_pkg::dir_e     m_we_o,
   output wb_pkg::adr_t     m_adr_o,
   output smp_pkg::sample_t m_dat_o,
   input  logic             m_ack_i,
   input  logic             m_wat_i,
   input  smp_pkg::sample_t m_dat_i,

   // One-cycle pulse after the last word has been accepted
   output logic             wrap_o
);

   localparam int WORDS = 1 << WBITS;
   localparam int LAST  = START + WORDS - STEP;

   logic         inc;
   logic         wrap_adr;
   wb_pkg::adr_t next_adr;

   // ----------------------------------------------------------
   // Bus pass-through for everything but the address
   // ----------------------------------------------------------
   assign m_cyc_o = s_cyc_i;
   assign m_stb_o = s_stb_i;
   assign m_we_o  = s_we_i;
   assign m_dat_o = s_dat_i;

   assign s_ack_o = m_ack_i;
   assign s_wat_o = m_wat_i;
   assign s_dat_o = m_dat_i;

   // ----------------------------------------------------------
   // Sequential address generation
   // ----------------------------------------------------------
   // A pipelined transfer counts once the strobe is taken
   assign inc      = m_cyc_o && m_stb_o && !m_wat_i;
   assign wrap_adr = (m_adr_o == wb_pkg::adr_t'(LAST));
   assign next_adr = wrap_adr ? wb_pkg::adr_t'(START) : wb_pkg::adr_t'(m_adr_o + STEP);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         m_adr_o <= wb_pkg::adr_t'(START);
      end else if (inc) begin
         m_adr_o <= next_adr;
      end
   end

   // Registered wrap flag that stays high for one cycle only
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrap_o <= 1'b0;
      end else begin
         wrap_o <= inc && wrap_adr;
      end
   end

   // Address stays inside the buffer window across every wrap
   adr_in_range_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      int'(m_adr_o) >= START && int'(m_adr_o) <= LAST
   );

endmodule

`default_nettype wire

// ==== design/sbuf_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module sbuf_ram (
   input  logic             clk_i,
   input  logic             rst_i,

   // Port a as a pipelined slave
   input  logic             a_cyc_i,
   input  logic             a_stb_i,
   input  wb_pkg::dir_e     a_we_i,
   input  wb_pkg::adr_t     a_adr_i,
   input  smp_pkg::sample_t a_dat_i,
   output logic             a_ack_o,
   output smp_pkg::sample_t a_dat_o,

   // Port b as a pipelined slave
   input  logic             b_cyc_i,
   input  logic             b_stb_i,
   input  wb_pkg::dir_e     b_we_i,
   input  wb_pkg::adr_t     b_adr_i,
   input  smp_pkg::sample_t b_dat_i,
   output logic             b_ack_o,
   output smp_pkg::sample_t b_dat_o
);

   localparam int WORDS = 1 << `SBUF_WBITS;

   smp_pkg::sample_t mem [0:WORDS-1];

   logic a_acc;
   logic b_acc;

   // Never stalls so any strobe inside a cycle is taken
   assign a_acc = a_cyc_i && a_stb_i;
   assign b_acc = b_cyc_i && b_stb_i;

   // ----------------------------------------------------------
   // Storage writes where port b wins on an address collision
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (a_acc && a_we_i == wb_pkg::WB_WRITE) begin
         mem[a_adr_i] <= a_dat_i;
      end
      if (b_acc && b_we_i == wb_pkg::WB_WRITE) begin
         mem[b_adr_i] <= b_dat_i;
      end
   end

   // Registered read data that is valid alongside the acknowledge
   always_ff @(posedge clk_i) begin
      if (a_acc && a_we_i == wb_pkg::WB_READ) begin
         a_dat_o <= mem[a_adr_i];
      end
      if (b_acc && b_we_i == wb_pkg::WB_READ) begin
         b_dat_o <= mem[b_adr_i];
      end
   end

   // ----------------------------------------------------------
   // Acknowledge one cycle behind the strobe
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         a_ack_o <= 1'b0;
         b_ack_o <= 1'b0;
      end else begin
         a_ack_o <= a_acc;
         b_ack_o <= b_acc;
      end
   end

endmodule

`default_nettype wire

// ==== design/stream_reader.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module stream_reader (
   input  logic             clk_i,
   input  logic             rst_i,

   // One-cycle start strobe, ignored while busy
   input  logic             start_i,

   // Pipelined master, address comes from the stream port
   output logic             m_cyc_o,
   output logic             m_stb_o,
   output wb_pkg::dir_e     m_we_o,
   input  logic             m_ack_i,
   input  logic             m_wat_i,
   input  smp_pkg::sample_t m_dat_i,

   // Readout samples
   output smp_pkg::sample_t data_o,
   output logic             data_valid_o,
   output logic             done_o
);

   localparam smp_pkg::count_t WORDS = smp_pkg::count_t'(1 << `SBUF_WBITS);
   localparam smp_pkg::count_t LAST  = smp_pkg::count_t'(WORDS - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_DRAIN
   } state_e;

   state_e          state;
   smp_pkg::count_t iss_cnt;
   smp_pkg::count_t ack_cnt;
   logic            accept;

   assign accept = m_cyc_o && m_stb_o && !m_wat_i;

   // Reads only
   assign m_we_o = wb_pkg::WB_READ;

   // ----------------------------------------------------------
   // Sample output, straight from the acknowledge
   // ----------------------------------------------------------
   assign data_o       = m_dat_i;
   assign data_valid_o = m_ack_i;
   assign done_o       = m_ack_i && (ack_cnt == LAST);

   // ----------------------------------------------------------
   // Idle / issue / drain controller
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= ST_IDLE;
         m_cyc_o <= 1'b0;
         m_stb_o <= 1'b0;
         iss_cnt <= '0;
         ack_cnt <= '0;
      end else begin
         // Acknowledges may trail the strobes by a cycle
         if (m_ack_i) begin
            ack_cnt <= ack_cnt + 1'b1;
         end
         case (state)
            ST_IDLE: begin
               if (start_i) begin
                  state   <= ST_ISSUE;
                  m_cyc_o <= 1'b1;
                  m_stb_o <= 1'b1;
                  iss_cnt <= '0;
                  ack_cnt <= '0;
               end
            end
            ST_ISSUE: begin
               if (accept) begin
                  iss_cnt <= iss_cnt + 1'b1;
                  // Last strobe taken, hold cyc for the trailing acks
                  if (iss_cnt == LAST) begin
                     m_stb_o <= 1'b0;
                     state   <= ST_DRAIN;
                  end
               end
            end
            ST_DRAIN: begin
               if (m_ack_i && ack_cnt == LAST) begin
                  m_cyc_o <= 1'b0;
                  state   <= ST_IDLE;
               end
            end
            default: begin
               state   <= ST_IDLE;
               m_cyc_o <= 1'b0;
               m_stb_o <= 1'b0;
            end
         endcase
      end
   end

   stb_within_cyc_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      m_stb_o |-> m_cyc_o
   );

endmodule

`default_nettype wire

// ==== design/sbuf_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module sbuf_top (
   input  logic             clk_i,
   input  logic             rst_i,

   // Write side, one-cycle sample strobe
   input  smp_pkg::sample_t sample_i,
   input  logic             sample_valid_i,

   // Readout side
   input  logic             start_i,
   output smp_pkg::sample_t data_o,
   output logic             data_valid_o,
   output logic             done_o,

   // Address wrap pulses
   output logic             wr_wrap_o,
   output logic             rd_wrap_o
);

   // Write stream to RAM port a
   logic             wr_cyc;
   logic             wr_stb;
   wb_pkg::dir_e     wr_we;
   wb_pkg::adr_t     wr_adr;
   smp_pkg::sample_t wr_dat;
   logic             wr_ack;
   smp_pkg::sample_t wr_rdat;

   // Reader to read stream
   logic             rdr_cyc;
   logic             rdr_stb;
   wb_pkg::dir_e     rdr_we;
   logic             rdr_ack;
   logic             rdr_wat;
   smp_pkg::sample_t rdr_dat;

   // Read stream to RAM port b
   logic             rd_cyc;
   logic             rd_stb;
   wb_pkg::dir_e     rd_we;
   wb_pkg::adr_t     rd_adr;
   smp_pkg::sample_t rd_wdat;
   logic             rd_ack;
   smp_pkg::sample_t rd_dat;

   // The RAM never stalls
   logic             ram_wat;
   assign ram_wat = 1'b0;

   // ----------------------------------------------------------
   // Write path, the strobe doubles as cyc and stb
   // ----------------------------------------------------------
   wb_stream_adr #(
      .WBITS (`SBUF_WBITS),
      .START (`SBUF_START),
      .STEP  (`SBUF_STEP)
   ) u_wr_stream (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .s_cyc_i (sample_valid_i),
      .s_stb_i (sample_valid_i),
      .s_we_i  (wb_pkg::WB_WRITE),
      .s_dat_i (sample_i),
      .s_ack_o (),
      .s_wat_o (),
      .s_dat_o (),
      .m_cyc_o (wr_cyc),
      .m_stb_o (wr_stb),
      .m_we_o  (wr_we),
      .m_adr_o (wr_adr),
      .m_dat_o (wr_dat),
      .m_ack_i (wr_ack),
      .m_wat_i (ram_wat),
      .m_dat_i (wr_rdat),
      .wrap_o  (wr_wrap_o)
   );

   // ----------------------------------------------------------
   // Read path
   // ----------------------------------------------------------
   stream_reader u_reader (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .m_cyc_o      (rdr_cyc),
      .m_stb_o      (rdr_stb),
      .m_we_o       (rdr_we),
      .m_ack_i      (rdr_ack),
      .m_wat_i      (rdr_wat),
      .m_dat_i      (rdr_dat),
      .data_o       (data_o),
      .data_valid_o (data_valid_o),
      .done_o       (done_o)
   );

   wb_stream_adr #(
      .WBITS (`SBUF_WBITS),
      .START (`SBUF_START),
      .STEP  (`SBUF_STEP)
   ) u_rd_stream (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .s_cyc_i (rdr_cyc),
      .s_stb_i (rdr_stb),
      .s_we_i  (rdr_we),
      .s_dat_i ('0),
      .s_ack_o (rdr_ack),
      .s_wat_o (rdr_wat),
      .s_dat_o (rdr_dat),
      .m_cyc_o (rd_cyc),
      .m_stb_o (rd_stb),
      .m_we_o  (rd_we),
      .m_adr_o (rd_adr),
      .m_dat_o (rd_wdat),
      .m_ack_i (rd_ack),
      .m_wat_i (ram_wat),
      .m_dat_i (rd_dat),
      .wrap_o  (rd_wrap_o)
   );

   // ----------------------------------------------------------
   // Sample storage
   // ----------------------------------------------------------
   sbuf_ram u_ram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .a_cyc_i (wr_cyc),
      .a_stb_i (wr_stb),
      .a_we_i  (wr_we),
      .a_adr_i (wr_adr),
      .a_dat_i (wr_dat),
      .a_ack_o (wr_ack),
      .a_dat_o (wr_rdat),
      .b_cyc_i (rd_cyc),
      .b_stb_i (rd_stb),
      .b_we_i  (rd_we),
      .b_adr_i (rd_adr),
      .b_dat_i (rd_wdat),
      .b_ack_o (rd_ack),
      .b_dat_o (rd_dat)
   );

endmodule

`default_nettype wire

// ==== test/sbuf_checker.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module sbuf_checker (
   input  logic             clk_i,
   input  logic             rst_i,

   // DUT inputs, as seen at the sampling edge
   input  logic             sample_valid_i,
   input  logic             start_i,

   // DUT outputs under watch
   input  smp_pkg::sample_t data_i,
   input  logic             data_valid_i,
   input  logic             done_i,
   input  logic             wr_wrap_i,
   input  logic             rd_wrap_i,

   // Running totals for the bench
   output int               errors_o,
   output int               samples_o,
   output int               dones_o,
   output int               wr_wraps_o,
   output int               rd_wraps_o
);

   localparam int WORDS     = 1 << `SBUF_WBITS;
   // Edges from the accepted start to the first and last valid sample
   localparam int FIRST_LAT = 2;
   localparam int LAST_LAT  = FIRST_LAT + WORDS - 1;

   smp_pkg::sample_t exp_q [$];
   smp_pkg::sample_t exp_dat;

   int   err_cnt;
   int   smp_cnt;
   int   done_cnt;
   int   wr_wrap_cnt;
   int   rd_wrap_cnt;

   // Reference model state
   int   wr_cnt;
   logic wr_last;
   logic rd_busy;
   int   rd_k;
   logic exp_valid;
   logic exp_last;

   initial begin
      err_cnt     = 0;
      smp_cnt     = 0;
      done_cnt    = 0;
      wr_wrap_cnt = 0;
      rd_wrap_cnt = 0;
   end

   assign errors_o   = err_cnt;
   assign samples_o  = smp_cnt;
   assign dones_o    = done_cnt;
   assign wr_wraps_o = wr_wrap_cnt;
   assign rd_wraps_o = rd_wrap_cnt;

   // Next sample the readout should deliver
   task automatic push_expected(input smp_pkg::sample_t dat);
      exp_q.push_back(dat);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("ERR %0t %s expected %0b got %0b", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   // ----------------------------------------------------------
   // Cycle-by-cycle comparison
   // ----------------------------------------------------------
   // Outputs read here were set at the previous edge
   always @(posedge clk_i) begin
      if (rst_i) begin
         wr_cnt  = 0;
         wr_last = 1'b0;
         rd_busy = 1'b0;
         rd_k    = 0;
      end else begin
         if (rd_busy) begin
            rd_k = rd_k + 1;
         end
         exp_valid = rd_busy && (rd_k >= FIRST_LAT) && (rd_k <= LAST_LAT);
         exp_last  = rd_busy && (rd_k == LAST_LAT);

         check_bit("wr_wrap_o", wr_last, wr_wrap_i);
         check_bit("data_valid_o", exp_valid, data_valid_i);
         check_bit("done_o", exp_last, done_i);
         check_bit("rd_wrap_o", exp_last, rd_wrap_i);

         if (exp_valid) begin
            if (exp_q.size() == 0) begin
               $display("At %0t a readout sample was due but none was left to expect",
                        $time);
               err_cnt++;
            end else begin
               exp_dat = exp_q.pop_front();
               if (data_i !== exp_dat) begin
                  $display("ERR %0t data_o expected %02h got %02h",
                           $time, exp_dat, data_i);
                  err_cnt++;
               end
            end
         end

         // Totals of what the DUT actually produced
         if (data_valid_i) smp_cnt++;
         if (done_i) done_cnt++;
         if (wr_wrap_i) wr_wrap_cnt++;
         if (rd_wrap_i) rd_wrap_cnt++;

         // Write side, wrap follows the last-address write
         wr_last = sample_valid_i && (wr_cnt == WORDS - 1);
         if (sample_valid_i) begin
            wr_cnt = (wr_cnt == WORDS - 1) ? 0 : wr_cnt + 1;
         end

         // Read side, start is ignored until the last sample
         if (rd_busy && rd_k == LAST_LAT) begin
            rd_busy = 1'b0;
         end else if (!rd_busy && start_i) begin
            rd_busy = 1'b1;
            rd_k    = 0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/sbuf_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "sbuf_defines.svh"

module sbuf_tb;

   localparam int WORDS    = 1 << `SBUF_WBITS;
   localparam int ROWS     = WORDS;
   localparam int COLS     = 4;
   localparam int RST_CYC  = 10;
   localparam int MAX_GAP  = 4;
   // Watchdog budget in clock cycles
   localparam int WDOG_CYC = ROWS * 4 + 200;

   logic             clk;
   logic             rst;
   smp_pkg::sample_t sample;
   logic             sample_valid;
   logic             start;
   smp_pkg::sample_t data;
   logic             data_valid;
   logic             done;
   logic             wr_wrap;
   logic             rd_wrap;

   int errors;
   int samples;
   int dones;
   int wr_wraps;
   int rd_wraps;

   // Columns: pass 1 write, pass 1 expected, pass 2 write, pass 2 expected
   smp_pkg::sample_t vec [0:ROWS*COLS-1];

   integer seed;
   int     tb_errs;
   int     n_pass;
   int     n_fail;
   int     mark_err;
   int     mark_smp;
   int     mark_done;
   int     mark_wrw;
   int     mark_rdw;

   sbuf_top i_sbuf_top (
      .clk_i          (clk),
      .rst_i          (rst),
      .sample_i       (sample),
      .sample_valid_i (sample_valid),
      .start_i        (start),
      .data_o         (data),
      .data_valid_o   (data_valid),
      .done_o         (done),
      .wr_wrap_o      (wr_wrap),
      .rd_wrap_o      (rd_wrap)
   );

   sbuf_checker u_checker (
      .clk_i          (clk),
      .rst_i          (rst),
      .sample_valid_i (sample_valid),
      .start_i        (start),
      .data_i         (data),
      .data_valid_i   (data_valid),
      .done_i         (done),
      .wr_wrap_i      (wr_wrap),
      .rd_wrap_i      (rd_wrap),
      .errors_o       (errors),
      .samples_o      (samples),
      .dones_o        (dones),
      .wr_wraps_o     (wr_wraps),
      .rd_wraps_o     (rd_wraps)
   );

   // ----------------------------------------------------------
   // Clock and watchdog
   // ----------------------------------------------------------
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WDOG_CYC);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ----------------------------------------------------------
   // Helper tasks, all entered and left on a falling edge
   // ----------------------------------------------------------
   task automatic begin_test();
      mark_err  = errors + tb_errs;
      mark_smp  = samples;
      mark_done = dones;
      mark_wrw  = wr_wraps;
      mark_rdw  = rd_wraps;
   endtask

   task automatic end_test(input int num, input string name);
      int fails;
      fails = errors + tb_errs - mark_err;
      if (fails == 0) begin
         $display("test %0d %s: ok", num, name);
         n_pass++;
      end else begin
         $display("test %0d %s: failed with %0d errors", num, name, fails);
         n_fail++;
      end
   endtask

   task automatic check_count(input string what, input int exp, input int got);
      if (got != exp) begin
         $display("Counted %0d %s where %0d were expected", got, what, exp);
         tb_errs++;
      end
   endtask

   // Sixteen one-cycle write strobes with random idle gaps
   task automatic write_pass(input int col);
      int i;
      int gap;
      for (i = 0; i < ROWS; i++) begin
         gap = {$random(seed)} % MAX_GAP;
         repeat (gap) @(negedge clk);
         sample       = vec[i*COLS+col];
         sample_valid = 1'b1;
         @(negedge clk);
         sample_valid = 1'b0;
      end
   endtask

   task automatic load_expected(input int col);
      int i;
      for (i = 0; i < ROWS; i++) begin
         u_checker.push_expected(vec[i*COLS+col]);
      end
   endtask

   task automatic pulse_start();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_done(input int limit);
      int n;
      n = 0;
      while (!done && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         $display("done_o did not arrive within %0d cycles", limit);
         tb_errs++;
      end
      // Let the checker see the final edge
      repeat (2) @(negedge clk);
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      seed         = 8;
      tb_errs      = 0;
      n_pass       = 0;
      n_fail       = 0;
      rst          = 1'b1;
      sample       = '0;
      sample_valid = 1'b0;
      start        = 1'b0;
      $readmemh("test/sbuf_input.dat", vec);
      repeat (RST_CYC) @(negedge clk);
      rst = 1'b0;

      // Quiet outputs with nothing applied
      begin_test();
      repeat (RST_CYC) @(negedge clk);
      end_test(1, "idle after reset");

      // Fill the buffer, one wrap pulse expected
      begin_test();
      write_pass(0);
      repeat (2) @(negedge clk);
      check_count("write wrap pulses", 1, wr_wraps - mark_wrw);
      end_test(2, "write and wrap");

      // Full readout in write order
      begin_test();
      load_expected(1);
      pulse_start();
      wait_done(4 * WORDS);
      check_count("valid samples", WORDS, samples - mark_smp);
      end_test(3, "readout order");

      // Same buffer again, one done and one read wrap
      begin_test();
      load_expected(1);
      pulse_start();
      wait_done(4 * WORDS);
      check_count("done pulses", 1, dones - mark_done);
      check_count("read wrap pulses", 1, rd_wraps - mark_rdw);
      end_test(4, "done and read wrap");

      // Overwrite, then a start in mid readout must be ignored
      begin_test();
      write_pass(2);
      load_expected(3);
      pulse_start();
      repeat (6) @(negedge clk);
      pulse_start();
      wait_done(4 * WORDS);
      repeat (WORDS) @(negedge clk);
      check_count("valid samples", WORDS, samples - mark_smp);
      check_count("read wrap pulses", 1, rd_wraps - mark_rdw);
      end_test(5, "overwrite and busy start");

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               n_pass + n_fail, n_pass, n_fail, errors + tb_errs);
      if (n_fail == 0 && errors + tb_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sbuf.f ====
+incdir+design
design/wb_pkg.sv
design/smp_pkg.sv
design/wb_stream_adr.sv
design/sbuf_ram.sv
design/stream_reader.sv
design/sbuf_top.sv
test/sbuf_checker.sv
test/sbuf_tb.sv

// ==== Makefile ====
# Verilator flow for the sample buffer
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= sbuf.f
TOP       ?= sbuf_tb
RTL_TOP   ?= sbuf_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint sim clean

all: sim

# Lint the RTL on its own, then the whole bench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/sbuf_input.dat ====
// Columns per row: pass 1 write sample, pass 1 expected readout,
// pass 2 write sample, pass 2 expected readout (hex, one row per address)
11 11 c0 c0
2e 2e d9 d9
43 43 e4 e4
5a 5a f7 f7
67 67 0a 0a
7c 7c 1d 1d
81 81 26 26
9f 9f 34 34
a2 a2 4f 4f
b8 b8 58 58
c5 c5 6b 6b
d3 d3 72 72
e6 e6 8c 8c
f1 f1 95 95
08 08 ad ad
3b 3b be be
